// File: bus_pkg.sv
package bus_pkg;

  // ring word widths
  localparam int BUS_AW = 32;
  localparam int BUS_DW = 32;

  // byte base address of each node window
  localparam logic [BUS_AW-1:0] LCD_BASE = 32'h1000_0000;
  localparam logic [BUS_AW-1:0] BL_BASE  = 32'h1000_0010;

  // 4 words per window
  localparam int WIN_WORDS_LOG2 = 2;

  // word offsets inside the display window
  localparam logic [WIN_WORDS_LOG2-1:0] REG_CMD    = 2'd0;
  localparam logic [WIN_WORDS_LOG2-1:0] REG_DATA   = 2'd1;
  localparam logic [WIN_WORDS_LOG2-1:0] REG_STATUS = 2'd2;

  // word offset inside the backlight window
  localparam logic [WIN_WORDS_LOG2-1:0] REG_DUTY   = 2'd0;

endpackage

// File: lcd_pkg.sv
package lcd_pkg;

  // one queued display byte
  // is_cmd set means RS_DC low on the wire
  typedef struct packed {
    logic       is_cmd;
    logic [7:0] value;
  } lcd_byte_t;

  // command FIFO size
  localparam int FIFO_DEPTH = 4;
  // level counts 0..FIFO_DEPTH
  localparam int FIFO_LW = 3;

  // system clocks per SCK half period
  localparam int SPI_HALF = 2;

  // idle clocks after reset before the first byte
  // short for simulation, a real panel wants far more
  localparam int POWERON_WAIT = 64;

  // bit periods of CS high between bytes
  localparam int CS_GAP = 1;

endpackage

// File: lcd_cmd_fifo.sv
module lcd_cmd_fifo (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_push,
  input  lcd_pkg::lcd_byte_t          i_din,
  input  logic                        i_pop,
  output lcd_pkg::lcd_byte_t          o_dout,
  output logic                        o_empty,
  output logic                        o_full,
  output logic [lcd_pkg::FIFO_LW-1:0] o_level
);
  import lcd_pkg::*;

  localparam int PW = $clog2(FIFO_DEPTH);

  lcd_byte_t     mem [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  // guarded strobes, the ports are trusted but never overrun the buffer
  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_level <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // push and pop together leave the level alone
      case ({do_push, do_pop})
        2'b10:   o_level <= o_level + 1'b1;
        2'b01:   o_level <= o_level - 1'b1;
        default: o_level <= o_level;
      endcase
    end
  end

  // storage, no reset
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= i_din;
  end

  // head entry visible before the pop
  assign o_dout  = mem[rd_ptr];
  assign o_empty = (o_level == '0);
  assign o_full  = (o_level == FIFO_LW'(FIFO_DEPTH));

  // serializer only pops a non-empty queue
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) i_pop |-> !o_empty)
    else $error("fifo popped while empty");
  // controller drops writes itself once full
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) i_push |-> !o_full)
    else $error("fifo pushed while full");

endmodule

// File: spi_lcd_serializer.sv
module spi_lcd_serializer (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_empty,
  input  lcd_pkg::lcd_byte_t i_byte,
  output logic               o_pop,
  output logic               o_busy,
  output logic               o_sck,
  output logic               o_data,
  output logic               o_rs_dc,
  output logic               o_cs
);
  import lcd_pkg::*;

  // clocks per SPI bit and per inter-byte gap
  localparam int BIT_CLKS = 2 * SPI_HALF;
  localparam int GAP_CLKS = CS_GAP * BIT_CLKS;
  localparam int DIV_W    = $clog2(BIT_CLKS);
  // one timer serves both the power-on wait and the gap
  localparam int TMR_W    = $clog2(POWERON_WAIT + GAP_CLKS);

  typedef enum logic [1:0] {
    ST_WAIT,
    ST_IDLE,
    ST_SHIFT,
    ST_GAP
  } state_t;

  state_t           state;
  logic [TMR_W-1:0] tmr;
  logic [DIV_W-1:0] div;
  logic [2:0]       bit_idx;
  logic [7:0]       byte_q;

  // take the head byte as soon as idle
  assign o_pop  = (state == ST_IDLE) && !i_empty;
  assign o_busy = (state == ST_SHIFT) || (state == ST_GAP);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= ST_WAIT;
      tmr     <= TMR_W'(POWERON_WAIT - 1);
      div     <= '0;
      bit_idx <= '0;
      o_cs    <= 1'b1;
      o_sck   <= 1'b0;
      o_data  <= 1'b0;
      o_rs_dc <= 1'b0;
    end
    else
    begin
      case (state)
        // panel power-on settle, pins parked
        ST_WAIT:
        begin
          if (tmr == '0)
            state <= ST_IDLE;
          else
            tmr <= tmr - 1'b1;
        end
        ST_IDLE:
        begin
          if (!i_empty)
          begin
            // open the frame with the MSB already on DATA
            state   <= ST_SHIFT;
            o_cs    <= 1'b0;
            o_rs_dc <= !i_byte.is_cmd;
            o_data  <= i_byte.value[7];
            div     <= '0;
            bit_idx <= 3'd7;
          end
        end
        ST_SHIFT:
        begin
          if (div == DIV_W'(BIT_CLKS - 1))
          begin
            // end of bit period, SCK falls here
            div   <= '0;
            o_sck <= 1'b0;
            if (bit_idx == 3'd0)
            begin
              state <= ST_GAP;
              o_cs  <= 1'b1;
              tmr   <= TMR_W'(GAP_CLKS - 1);
            end
            else
            begin
              bit_idx <= bit_idx - 3'd1;
              o_data  <= byte_q[bit_idx - 3'd1];
            end
          end
          else
          begin
            div <= div + 1'b1;
            // second half of the bit, panel samples on this rise
            if (div == DIV_W'(SPI_HALF - 1))
              o_sck <= 1'b1;
          end
        end
        ST_GAP:
        begin
          if (tmr == '0)
            state <= ST_IDLE;
          else
            tmr <= tmr - 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // byte being shifted, no reset
  always_ff @(posedge clk)
  begin
    if (o_pop)
      byte_q <= i_byte.value;
  end

  // clock only toggles inside a frame
  a_sck_idle_low: assert property (@(posedge clk) disable iff (rst) o_cs |-> !o_sck)
    else $error("sck high while cs deasserted");

endmodule

// File: st7735r_ctrl.sv
module st7735r_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_bus_req,
  input  logic                       i_bus_ack,
  input  logic                       i_bus_write,
  input  logic [bus_pkg::BUS_AW-1:0] i_bus_addr,
  input  logic [bus_pkg::BUS_DW-1:0] i_bus_data,
  output logic                       o_bus_req,
  output logic                       o_bus_ack,
  output logic                       o_bus_write,
  output logic [bus_pkg::BUS_AW-1:0] o_bus_addr,
  output logic [bus_pkg::BUS_DW-1:0] o_bus_data,
  output logic                       o_sck,
  output logic                       o_data,
  output logic                       o_rs_dc,
  output logic                       o_cs
);
  import bus_pkg::*;
  import lcd_pkg::*;

  // lowest address bit above the window offset
  localparam int WIN_LSB = WIN_WORDS_LOG2 + 2;

  logic                      hit;
  logic [WIN_WORDS_LOG2-1:0] reg_off;
  logic                      wr_byte;
  logic                      push;
  lcd_byte_t                 push_byte;
  lcd_byte_t                 fifo_dout;
  logic                      fifo_empty;
  logic                      fifo_full;
  logic [FIFO_LW-1:0]        fifo_level;
  logic                      pop;
  logic                      busy;
  logic                      overflow;
  logic [BUS_DW-1:0]         status_word;

  // window decode
  assign hit     = i_bus_req && (i_bus_addr[BUS_AW-1:WIN_LSB] == LCD_BASE[BUS_AW-1:WIN_LSB]);
  assign reg_off = i_bus_addr[WIN_LSB-1:2];

  // CMD and DATA writes queue the low byte
  assign wr_byte          = hit && i_bus_write && (reg_off == REG_CMD || reg_off == REG_DATA);
  assign push             = wr_byte && !fifo_full;
  assign push_byte.is_cmd = (reg_off == REG_CMD);
  assign push_byte.value  = i_bus_data[7:0];

  // level [2:0], overflow [4], busy [5]
  assign status_word = {{(BUS_DW - FIFO_LW - 3){1'b0}}, busy, overflow, 1'b0, fifo_level};

  // claimed words stop here
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_bus_req <= 1'b0;
      o_bus_ack <= 1'b0;
    end
    else
    begin
      o_bus_req <= i_bus_req && !hit;
      o_bus_ack <= i_bus_ack || hit;
    end
  end

  // payload passes through except on a claimed read
  always_ff @(posedge clk)
  begin
    o_bus_write <= i_bus_write;
    o_bus_addr  <= i_bus_addr;
    o_bus_data  <= i_bus_data;
    if (hit && !i_bus_write)
      o_bus_data <= (reg_off == REG_STATUS) ? status_word : '0;
  end

  // sticky overflow cleared by any STATUS write
  always_ff @(posedge clk)
  begin
    if (rst)
      overflow <= 1'b0;
    else if (wr_byte && fifo_full)
      overflow <= 1'b1;
    else if (hit && i_bus_write && reg_off == REG_STATUS)
      overflow <= 1'b0;
  end

  lcd_cmd_fifo u_fifo (
    .clk     (clk),
    .rst     (rst),
    .i_push  (push),
    .i_din   (push_byte),
    .i_pop   (pop),
    .o_dout  (fifo_dout),
    .o_empty (fifo_empty),
    .o_full  (fifo_full),
    .o_level (fifo_level)
  );

  spi_lcd_serializer u_ser (
    .clk     (clk),
    .rst     (rst),
    .i_empty (fifo_empty),
    .i_byte  (fifo_dout),
    .o_pop   (pop),
    .o_busy  (busy),
    .o_sck   (o_sck),
    .o_data  (o_data),
    .o_rs_dc (o_rs_dc),
    .o_cs    (o_cs)
  );

  // an ack raised by this node marks a claim and must leave with req low
  a_claim_ends_req: assert property (@(posedge clk) disable iff (rst)
    (o_bus_ack && !$past(i_bus_ack)) |-> !o_bus_req)
    else $error("claimed ring word left with req high");

endmodule

// File: backlight_pwm.sv
module backlight_pwm (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_bus_req,
  input  logic                       i_bus_ack,
  input  logic                       i_bus_write,
  input  logic [bus_pkg::BUS_AW-1:0] i_bus_addr,
  input  logic [bus_pkg::BUS_DW-1:0] i_bus_data,
  output logic                       o_bus_req,
  output logic                       o_bus_ack,
  output logic                       o_bus_write,
  output logic [bus_pkg::BUS_AW-1:0] o_bus_addr,
  output logic [bus_pkg::BUS_DW-1:0] o_bus_data,
  output logic                       o_bl_pwm
);
  import bus_pkg::*;

  localparam int WIN_LSB = WIN_WORDS_LOG2 + 2;

  logic                      hit;
  logic [WIN_WORDS_LOG2-1:0] reg_off;
  logic [7:0]                duty;
  logic [7:0]                pwm_cnt;

  assign hit     = i_bus_req && (i_bus_addr[BUS_AW-1:WIN_LSB] == BL_BASE[BUS_AW-1:WIN_LSB]);
  assign reg_off = i_bus_addr[WIN_LSB-1:2];

  // ring control and duty register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_bus_req <= 1'b0;
      o_bus_ack <= 1'b0;
      duty      <= '0;
    end
    else
    begin
      o_bus_req <= i_bus_req && !hit;
      o_bus_ack <= i_bus_ack || hit;
      if (hit && i_bus_write && reg_off == REG_DUTY)
        duty <= i_bus_data[7:0];
    end
  end

  // ring payload, read of DUTY returns it zero extended
  always_ff @(posedge clk)
  begin
    o_bus_write <= i_bus_write;
    o_bus_addr  <= i_bus_addr;
    o_bus_data  <= i_bus_data;
    if (hit && !i_bus_write)
      o_bus_data <= (reg_off == REG_DUTY) ? {{(BUS_DW - 8){1'b0}}, duty} : '0;
  end

  // free running period of 256 clocks
  // high for exactly duty counts, 0 means off
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pwm_cnt  <= '0;
      o_bl_pwm <= 1'b0;
    end
    else
    begin
      pwm_cnt  <= pwm_cnt + 1'b1;
      o_bl_pwm <= (pwm_cnt < duty);
    end
  end

endmodule

// File: lcd_subsystem_top.sv
module lcd_subsystem_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_bus_req,
  input  logic                       i_bus_ack,
  input  logic                       i_bus_write,
  input  logic [bus_pkg::BUS_AW-1:0] i_bus_addr,
  input  logic [bus_pkg::BUS_DW-1:0] i_bus_data,
  output logic                       o_bus_req,
  output logic                       o_bus_ack,
  output logic                       o_bus_write,
  output logic [bus_pkg::BUS_AW-1:0] o_bus_addr,
  output logic [bus_pkg::BUS_DW-1:0] o_bus_data,
  output logic                       o_sck,
  output logic                       o_data,
  output logic                       o_rs_dc,
  output logic                       o_cs,
  output logic                       o_bl_pwm
);
  import bus_pkg::*;

  // ring segment between display node and backlight node
  logic              mid_req;
  logic              mid_ack;
  logic              mid_write;
  logic [BUS_AW-1:0] mid_addr;
  logic [BUS_DW-1:0] mid_data;

  // first hop, display controller
  st7735r_ctrl u_lcd (
    .clk         (clk),
    .rst         (rst),
    .i_bus_req   (i_bus_req),
    .i_bus_ack   (i_bus_ack),
    .i_bus_write (i_bus_write),
    .i_bus_addr  (i_bus_addr),
    .i_bus_data  (i_bus_data),
    .o_bus_req   (mid_req),
    .o_bus_ack   (mid_ack),
    .o_bus_write (mid_write),
    .o_bus_addr  (mid_addr),
    .o_bus_data  (mid_data),
    .o_sck       (o_sck),
    .o_data      (o_data),
    .o_rs_dc     (o_rs_dc),
    .o_cs        (o_cs)
  );

  // second hop, backlight
  backlight_pwm u_bl (
    .clk         (clk),
    .rst         (rst),
    .i_bus_req   (mid_req),
    .i_bus_ack   (mid_ack),
    .i_bus_write (mid_write),
    .i_bus_addr  (mid_addr),
    .i_bus_data  (mid_data),
    .o_bus_req   (o_bus_req),
    .o_bus_ack   (o_bus_ack),
    .o_bus_write (o_bus_write),
    .o_bus_addr  (o_bus_addr),
    .o_bus_data  (o_bus_data),
    .o_bl_pwm    (o_bl_pwm)
  );

endmodule

// File: tb_lcd_subsystem.sv
module tb_lcd_subsystem;
  import bus_pkg::*;
  import lcd_pkg::*;

  // byte addresses of the registers under test
  localparam logic [BUS_AW-1:0] A_CMD  = LCD_BASE + BUS_AW'(REG_CMD) * 4;
  localparam logic [BUS_AW-1:0] A_DATA = LCD_BASE + BUS_AW'(REG_DATA) * 4;
  localparam logic [BUS_AW-1:0] A_STAT = LCD_BASE + BUS_AW'(REG_STATUS) * 4;
  localparam logic [BUS_AW-1:0] A_DUTY = BL_BASE + BUS_AW'(REG_DUTY) * 4;
  localparam int BIT_CLKS   = 2 * SPI_HALF;
  localparam int TMO_MARGIN = 200;

  // one ring operation with its expected response
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_rd;
    logic        claim;
    logic        ack_in;
    logic        spi;
    logic        pwm;
  } ring_op_t;

  logic clk = 1'b0;
  logic rst;
  logic i_bus_req;
  logic i_bus_ack;
  logic i_bus_write;
  logic [BUS_AW-1:0] i_bus_addr;
  logic [BUS_DW-1:0] i_bus_data;
  logic o_bus_req;
  logic o_bus_ack;
  logic o_bus_write;
  logic [BUS_AW-1:0] o_bus_addr;
  logic [BUS_DW-1:0] o_bus_data;
  logic o_sck;
  logic o_data;
  logic o_rs_dc;
  logic o_cs;
  logic o_bl_pwm;

  ring_op_t   ops[$];
  string      op_names[$];
  // expected SPI bytes as {is_cmd, value}
  logic [8:0] exp_spi[$];
  int         cyc_run = 0;
  int         cyc_total = 0;
  int         tmo_limit;

  // SPI monitor state
  logic       cs_prev = 1'b1;
  logic       sck_prev = 1'b0;
  logic [7:0] shreg = 8'h00;
  logic       rs_seen = 1'b0;
  int         nbits = 0;
  int         nbytes = 0;

  lcd_subsystem_top UUT (
    .clk         (clk),
    .rst         (rst),
    .i_bus_req   (i_bus_req),
    .i_bus_ack   (i_bus_ack),
    .i_bus_write (i_bus_write),
    .i_bus_addr  (i_bus_addr),
    .i_bus_data  (i_bus_data),
    .o_bus_req   (o_bus_req),
    .o_bus_ack   (o_bus_ack),
    .o_bus_write (o_bus_write),
    .o_bus_addr  (o_bus_addr),
    .o_bus_data  (o_bus_data),
    .o_sck       (o_sck),
    .o_data      (o_data),
    .o_rs_dc     (o_rs_dc),
    .o_cs        (o_cs),
    .o_bl_pwm    (o_bl_pwm)
  );

  initial
  begin
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] want, input logic [31:0] got);
    if (want !== got)
      abort_run($sformatf("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, want, got));
  endtask

  task automatic add_row(input string name, input logic wr, input logic [31:0] addr,
                         input logic [31:0] data, input logic [31:0] exp_rd,
                         input logic claim, input logic ack_in, input logic spi,
                         input logic pwm);
    ops.push_back('{wr, addr, data, exp_rd, claim, ack_in, spi, pwm});
    op_names.push_back(name);
  endtask

  task automatic build_table();
    // first eight rows land inside the power-on wait
    add_row("cmd slpout", 1'b1, A_CMD, 32'h11, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0);
    add_row("data a5", 1'b1, A_DATA, 32'ha5, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0);
    add_row("cmd colmod", 1'b1, A_CMD, 32'h3a, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0);
    // only the low byte is queued
    add_row("data 05", 1'b1, A_DATA, 32'hffff_ff05, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0);
    add_row("data overflow", 1'b1, A_DATA, 32'h5a, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0);
    // level 4 plus overflow bit 4
    add_row("status full", 1'b0, A_STAT, 32'h0, 32'h14, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row("status clear", 1'b1, A_STAT, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row("status cleared", 1'b0, A_STAT, 32'h0, 32'h04, 1'b1, 1'b0, 1'b0, 1'b0);
    // outside both windows
    add_row("miss low", 1'b1, 32'h0, 32'hdead_beef, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row("miss above bl", 1'b0, 32'h1000_0020, 32'h1234_5678, 32'h0, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row("miss far", 1'b1, 32'h2000_0004, 32'h0bad_f00d, 32'h0, 1'b0, 1'b1, 1'b0, 1'b0);
    // backlight read rows also count pwm high clocks
    add_row("duty 64 write", 1'b1, A_DUTY, 32'h40, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row("duty 64 read", 1'b0, A_DUTY, 32'h0, 32'h40, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row("duty 255 write", 1'b1, A_DUTY, 32'hff, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row("duty 255 read", 1'b0, A_DUTY, 32'h0, 32'hff, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row("duty 0 write", 1'b1, A_DUTY, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row("duty 0 read", 1'b0, A_DUTY, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic apply_op(input int idx);
    ring_op_t    op;
    string       nm;
    logic [31:0] exp_data;
    logic        exp_ack;
    int          n_high;
    op       = ops[idx];
    nm       = op_names[idx];
    // claimed reads return the register and everything else passes through
    exp_data = (op.claim && !op.wr) ? op.exp_rd : op.data;
    exp_ack  = op.claim ? 1'b1 : op.ack_in;
    n_high   = 0;
    @(negedge clk);
    i_bus_req   = 1'b1;
    i_bus_ack   = op.ack_in;
    i_bus_write = op.wr;
    i_bus_addr  = op.addr;
    i_bus_data  = op.data;
    if (op.spi)
      exp_spi.push_back({op.addr == A_CMD, op.data[7:0]});
    @(negedge clk);
    i_bus_req   = 1'b0;
    i_bus_ack   = 1'b0;
    i_bus_write = 1'b0;
    i_bus_addr  = '0;
    i_bus_data  = '0;
    // word reaches the outputs after two hops
    @(negedge clk);
    check($sformatf("%s req", nm), 32'(!op.claim), 32'(o_bus_req));
    check($sformatf("%s ack", nm), 32'(exp_ack), 32'(o_bus_ack));
    check($sformatf("%s write", nm), 32'(op.wr), 32'(o_bus_write));
    check($sformatf("%s addr", nm), op.addr, o_bus_addr);
    check($sformatf("%s data", nm), exp_data, o_bus_data);
    if (op.pwm)
    begin
      repeat (256)
      begin
        @(negedge clk);
        if (o_bl_pwm)
          n_high++;
      end
      check($sformatf("%s pwm high clocks", nm), 32'(op.exp_rd[7:0]), 32'(n_high));
    end
  endtask

  // compare a finished frame against the next expected byte
  task automatic end_of_byte();
    logic [8:0] want;
    if (exp_spi.size() == 0)
      abort_run("SPI byte seen on the wire with no byte expected");
    else
    begin
      want = exp_spi.pop_front();
      check($sformatf("spi byte %0d sck pulses", nbytes), 32'd8, 32'(nbits));
      check($sformatf("spi byte %0d value", nbytes), 32'(want[7:0]), 32'(shreg));
      check($sformatf("spi byte %0d rs_dc", nbytes), 32'(!want[8]), 32'(rs_seen));
      nbytes++;
    end
  endtask

  // clocks since reset release and the run limit
  always @(posedge clk)
  begin
    if (rst)
      cyc_run <= 0;
    else
      cyc_run <= cyc_run + 1;
    cyc_total <= cyc_total + 1;
    if (cyc_total > tmo_limit)
      abort_run("timeout, the run took longer than its cycle limit");
  end

  // SPI monitor samples the pins away from the active edge
  always @(negedge clk)
  begin
    if (o_cs && o_sck)
      abort_run("SCK went high while CS was deasserted");
    else if (cs_prev && !o_cs && cyc_run <= POWERON_WAIT)
      abort_run("CS fell before the power-on wait had passed");
    else
    begin
      // frame start
      if (cs_prev && !o_cs)
        nbits = 0;
      // rising SCK is the panel sample point
      if (!o_cs && o_sck && !sck_prev)
      begin
        shreg   = {shreg[6:0], o_data};
        rs_seen = o_rs_dc;
        nbits++;
      end
      if (!cs_prev && o_cs)
        end_of_byte();
      cs_prev  = o_cs;
      sck_prev = o_sck;
    end
  end

  initial
  begin
    rst         = 1'b1;
    // ring held busy so only reset keeps req and ack low
    i_bus_req   = 1'b1;
    i_bus_ack   = 1'b1;
    i_bus_write = 1'b0;
    i_bus_addr  = '0;
    i_bus_data  = '0;
    build_table();
    // power-on wait plus every row as a full byte plus three pwm windows and a margin
    tmo_limit = POWERON_WAIT + ops.size() * 8 * BIT_CLKS + 3 * 256 + TMO_MARGIN;
    repeat (5) @(posedge clk);
    @(negedge clk);
    // pins parked while in reset
    check("reset cs", 32'd1, 32'(o_cs));
    check("reset sck", 32'd0, 32'(o_sck));
    check("reset data", 32'd0, 32'(o_data));
    check("reset rs_dc", 32'd0, 32'(o_rs_dc));
    check("reset ring req", 32'd0, 32'(o_bus_req));
    check("reset ring ack", 32'd0, 32'(o_bus_ack));
    check("reset bl_pwm", 32'd0, 32'(o_bl_pwm));
    i_bus_req = 1'b0;
    i_bus_ack = 1'b0;
    rst       = 1'b0;
    for (int i = 0; i < ops.size(); i++)
      apply_op(i);
    // let the queued bytes drain off the wire
    while (exp_spi.size() != 0 || !o_cs)
      @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: tb.f
bus_pkg.sv
lcd_pkg.sv
lcd_cmd_fifo.sv
spi_lcd_serializer.sv
st7735r_ctrl.sv
backlight_pwm.sv
lcd_subsystem_top.sv
tb_lcd_subsystem.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_lcd_subsystem -o sim_tb
./obj_dir/sim_tb
